/* Bender.yml */
package:
  name: dual_tlb_mmu

sources:
  # Package first, then interface, leaf blocks and the top level
  - files:
      - hdl/mmu_pkg.sv
      - hdl/tlb_update_if.sv
      - hdl/tlb.sv
      - hdl/page_table_walker.sv
      - hdl/mmu_request_router.sv
      - hdl/dual_tlb_mmu.sv

  # Testbench sources
  - target: test
    files:
      - verification/mmu_clock_gen.sv
      - verification/dual_tlb_mmu_tb.sv

/* dual_tlb_mmu.f */
hdl/mmu_pkg.sv
hdl/tlb_update_if.sv
hdl/tlb.sv
hdl/page_table_walker.sv
hdl/mmu_request_router.sv
hdl/dual_tlb_mmu.sv
verification/mmu_clock_gen.sv
verification/dual_tlb_mmu_tb.sv

/* hdl/dual_tlb_mmu.sv */
/*
 * Dual TLB Sv32 MMU top level
 * Private fetch and data TLBs sharing one page table walker
 */

`timescale 1ns/1ps

module dual_tlb_mmu import mmu_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  // Fetch port
  input  logic            if_req_valid,
  input  logic [xlen-1:0] if_req_vaddr,
  output logic            if_req_ready,
  output logic [xlen-1:0] if_req_paddr,
  output logic            if_req_page_fault,
  output logic [xlen-1:0] if_req_fault_vaddr,
  // Data port
  input  logic            ex_req_valid,
  input  logic [xlen-1:0] ex_req_vaddr,
  input  logic            ex_req_is_store,
  output logic            ex_req_ready,
  output logic [xlen-1:0] ex_req_paddr,
  output logic            ex_req_page_fault,
  output logic [xlen-1:0] ex_req_fault_vaddr,
  // Page table memory
  output logic            ptw_req_valid,
  output logic [xlen-1:0] ptw_req_addr,
  input  logic            ptw_req_ready,
  input  logic            ptw_resp_valid,
  input  logic [xlen-1:0] ptw_resp_data,
  // CSR state
  input  logic [xlen-1:0] satp,
  input  logic [1:0]      privilege_mode,
  input  logic            mstatus_sum,
  input  logic            mstatus_mxr,
  // Flush
  input  logic            tlb_flush_all,
  input  logic            tlb_flush_vaddr,
  input  logic [xlen-1:0] tlb_flush_addr
);

  logic            itlb_hit;
  logic [xlen-1:0] itlb_paddr;
  logic            itlb_fault;
  logic            dtlb_hit;
  logic [xlen-1:0] dtlb_paddr;
  logic            dtlb_fault;
  logic            walk_start;
  sv32_vaddr_t     walk_vaddr;
  logic            walk_done;
  logic            walk_fault;

  // Walker result and its two steered copies
  tlb_update_if walk_upd ();
  tlb_update_if itlb_upd ();
  tlb_update_if dtlb_upd ();

  tlb #(.num_entries(itlb_entries)) itlb (
    .clk, .reset_n,
    .lookup_valid    (if_req_valid),
    .lookup_vaddr    (if_req_vaddr),
    .lookup_is_store (1'b0),
    .lookup_is_fetch (1'b1),
    .privilege_mode, .mstatus_sum, .mstatus_mxr,
    .flush_all       (tlb_flush_all),
    .flush_vaddr     (tlb_flush_vaddr),
    .flush_addr      (tlb_flush_addr),
    .lookup_hit      (itlb_hit),
    .lookup_paddr    (itlb_paddr),
    .lookup_fault    (itlb_fault),
    .upd             (itlb_upd)
  );

  tlb #(.num_entries(dtlb_entries)) dtlb (
    .clk, .reset_n,
    .lookup_valid    (ex_req_valid),
    .lookup_vaddr    (ex_req_vaddr),
    .lookup_is_store (ex_req_is_store),
    .lookup_is_fetch (1'b0),
    .privilege_mode, .mstatus_sum, .mstatus_mxr,
    .flush_all       (tlb_flush_all),
    .flush_vaddr     (tlb_flush_vaddr),
    .flush_addr      (tlb_flush_addr),
    .lookup_hit      (dtlb_hit),
    .lookup_paddr    (dtlb_paddr),
    .lookup_fault    (dtlb_fault),
    .upd             (dtlb_upd)
  );

  mmu_request_router router (
    .clk, .reset_n, .satp, .privilege_mode,
    .if_req_valid, .if_req_vaddr, .ex_req_valid, .ex_req_vaddr,
    .itlb_hit, .itlb_paddr, .itlb_fault, .dtlb_hit, .dtlb_paddr, .dtlb_fault,
    .walk_done, .walk_fault,
    .translation_enabled (),
    .if_req_ready, .if_req_paddr, .if_req_page_fault, .if_req_fault_vaddr,
    .ex_req_ready, .ex_req_paddr, .ex_req_page_fault, .ex_req_fault_vaddr,
    .walk_start, .walk_vaddr,
    .walk_upd (walk_upd),
    .itlb_upd (itlb_upd),
    .dtlb_upd (dtlb_upd)
  );

  page_table_walker ptw (
    .clk, .reset_n, .walk_start, .walk_vaddr, .satp,
    .ptw_req_ready, .ptw_resp_valid, .ptw_resp_data,
    .walk_done, .walk_fault, .ptw_req_valid, .ptw_req_addr,
    .upd (walk_upd)
  );

endmodule

/* hdl/mmu_pkg.sv */
/*
 * Sv32 MMU shared definitions
 * Widths, TLB sizes, PTE flag positions, privilege codes, walker
 * state codes and the virtual address layout used by the TLBs and walker
 */

package mmu_pkg;

  // ==========================================================================
  // Widths and sizes
  // ==========================================================================

  localparam int xlen = 32;

  // Entries per TLB, instruction side is smaller
  localparam int itlb_entries = 8;
  localparam int dtlb_entries = 16;

  // Offset widths of a 4 KiB page and a 4 MiB megapage
  localparam int page_shift = 12;
  localparam int mega_shift = 22;

  // satp layout for RV32
  localparam int satp_mode_bit  = 31;
  localparam int satp_ppn_width = 22;

  // ==========================================================================
  // PTE flag bits, PPN sits in 31:10
  // ==========================================================================

  localparam int pte_v = 0;
  localparam int pte_r = 1;
  localparam int pte_w = 2;
  localparam int pte_x = 3;
  localparam int pte_u = 4;
  localparam int pte_a = 6;
  localparam int pte_d = 7;

  // Privilege levels
  localparam logic [1:0] priv_u = 2'b00;
  localparam logic [1:0] priv_s = 2'b01;
  localparam logic [1:0] priv_m = 2'b11;

  // Walker FSM
  localparam logic [1:0] ptw_st_idle = 2'd0;
  localparam logic [1:0] ptw_st_req  = 2'd1;
  localparam logic [1:0] ptw_st_wait = 2'd2;
  localparam logic [1:0] ptw_st_done = 2'd3;

  // Same address word seen as a 4K page or a megapage
  typedef union packed {
    struct packed {
      logic [9:0]            vpn1;
      logic [9:0]            vpn0;
      logic [page_shift-1:0] offset;
    } as_page;
    struct packed {
      logic [9:0]            vpn1;
      logic [mega_shift-1:0] offset;
    } as_mega;
  } sv32_vaddr_t;

endpackage

/* hdl/mmu_request_router.sv */
/*
 * MMU request router
 * Translation enable, miss detection, data-first walk arbitration,
 * walk ownership and the ready/paddr/fault responses of both ports
 */

`timescale 1ns/1ps

module mmu_request_router import mmu_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  input  logic [xlen-1:0] satp,
  input  logic [1:0]      privilege_mode,
  input  logic            if_req_valid,
  input  logic [xlen-1:0] if_req_vaddr,
  input  logic            ex_req_valid,
  input  logic [xlen-1:0] ex_req_vaddr,
  input  logic            itlb_hit,
  input  logic [xlen-1:0] itlb_paddr,
  input  logic            itlb_fault,
  input  logic            dtlb_hit,
  input  logic [xlen-1:0] dtlb_paddr,
  input  logic            dtlb_fault,
  input  logic            walk_done,
  input  logic            walk_fault,
  output logic            translation_enabled,
  output logic            if_req_ready,
  output logic [xlen-1:0] if_req_paddr,
  output logic            if_req_page_fault,
  output logic [xlen-1:0] if_req_fault_vaddr,
  output logic            ex_req_ready,
  output logic [xlen-1:0] ex_req_paddr,
  output logic            ex_req_page_fault,
  output logic [xlen-1:0] ex_req_fault_vaddr,
  output logic            walk_start,
  output sv32_vaddr_t     walk_vaddr,
  tlb_update_if.tlb       walk_upd,
  tlb_update_if.walker    itlb_upd,
  tlb_update_if.walker    dtlb_upd
);

  logic busy;
  // Walk belongs to the data port
  logic owner_ex;
  logic if_fault_q;
  logic ex_fault_q;
  logic if_pend;
  logic ex_pend;
  logic launch;

  // M mode always runs bare
  assign translation_enabled = satp[satp_mode_bit] && (privilege_mode != priv_m);

  // Misses not already being answered with a walk fault
  assign if_pend = translation_enabled && if_req_valid && !itlb_hit && !if_fault_q;
  assign ex_pend = translation_enabled && ex_req_valid && !dtlb_hit && !ex_fault_q;
  assign launch  = (if_pend || ex_pend) && !busy && !walk_start;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      walk_start <= 1'b0;
      busy       <= 1'b0;
      owner_ex   <= 1'b0;
      if_fault_q <= 1'b0;
      ex_fault_q <= 1'b0;
    end else begin
      walk_start <= launch;
      if (launch) begin
        // Data before fetch
        owner_ex <= ex_pend;
      end
      if (walk_start) begin
        busy <= 1'b1;
      end else if (walk_done) begin
        busy <= 1'b0;
      end
      if_fault_q <= walk_done && walk_fault && !owner_ex;
      ex_fault_q <= walk_done && walk_fault && owner_ex;
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      walk_vaddr <= ex_pend ? ex_req_vaddr : if_req_vaddr;
    end
  end

  // Fill goes only to the TLB that asked
  assign itlb_upd.valid = walk_upd.valid && !owner_ex;
  assign dtlb_upd.valid = walk_upd.valid && owner_ex;
  assign itlb_upd.vpn   = walk_upd.vpn;
  assign dtlb_upd.vpn   = walk_upd.vpn;
  assign itlb_upd.ppn   = walk_upd.ppn;
  assign dtlb_upd.ppn   = walk_upd.ppn;
  assign itlb_upd.flags = walk_upd.flags;
  assign dtlb_upd.flags = walk_upd.flags;
  assign itlb_upd.mega  = walk_upd.mega;
  assign dtlb_upd.mega  = walk_upd.mega;

  // ==========================================================================
  // Port responses, bare, TLB hit or walk fault
  // ==========================================================================

  assign if_req_ready       = if_req_valid && (!translation_enabled || itlb_hit || if_fault_q);
  assign if_req_paddr       = translation_enabled ? itlb_paddr : if_req_vaddr;
  assign if_req_page_fault  = translation_enabled && ((itlb_hit && itlb_fault) || if_fault_q);
  assign if_req_fault_vaddr = if_fault_q ? walk_vaddr : if_req_vaddr;

  assign ex_req_ready       = ex_req_valid && (!translation_enabled || dtlb_hit || ex_fault_q);
  assign ex_req_paddr       = translation_enabled ? dtlb_paddr : ex_req_vaddr;
  assign ex_req_page_fault  = translation_enabled && ((dtlb_hit && dtlb_fault) || ex_fault_q);
  assign ex_req_fault_vaddr = ex_fault_q ? walk_vaddr : ex_req_vaddr;

  // Walker only finishes a walk this router started and still owns
  assert property (@(posedge clk) disable iff (!reset_n) walk_done |-> busy);

endmodule

/* hdl/page_table_walker.sv */
/*
 * Two-level Sv32 page table walker
 * Reads the root then the leaf PTE over a valid/ready memory port,
 * flags structural faults and hands good leaves to the TLB fill bus
 */

`timescale 1ns/1ps

module page_table_walker import mmu_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            walk_start,
  input  sv32_vaddr_t     walk_vaddr,
  input  logic [xlen-1:0] satp,
  input  logic            ptw_req_ready,
  input  logic            ptw_resp_valid,
  input  logic [xlen-1:0] ptw_resp_data,
  output logic            walk_done,
  output logic            walk_fault,
  output logic            ptw_req_valid,
  output logic [xlen-1:0] ptw_req_addr,
  tlb_update_if.walker    upd
);

  logic [1:0]      state;
  // High while reading the root table
  logic            level;
  logic            fault_q;

  // Walk payload
  sv32_vaddr_t     va_q;
  logic [xlen-1:0] addr_q;
  logic [19:0]     leaf_ppn;
  logic [7:0]      leaf_flags;
  logic            leaf_mega;

  logic [satp_ppn_width+page_shift-1:0] root_addr;
  logic pte_valid;
  logic pte_leaf;
  logic pte_bad;

  // Root PPN times 4096 plus vpn1 times 4, upper bits dropped
  assign root_addr = {satp[satp_ppn_width-1:0], walk_vaddr.as_page.vpn1, 2'b00};

  // ==========================================================================
  // PTE decode
  // ==========================================================================

  assign pte_valid = ptw_resp_data[pte_v];
  assign pte_leaf  = ptw_resp_data[pte_r] || ptw_resp_data[pte_x];

  // V clear, W without R, pointer at level 0, misaligned megapage
  assign pte_bad = !pte_valid ||
                   (ptw_resp_data[pte_w] && !ptw_resp_data[pte_r]) ||
                   (!pte_leaf && !level) ||
                   (pte_leaf && level && ptw_resp_data[19:10] != '0);

  // ==========================================================================
  // FSM
  // ==========================================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state   <= ptw_st_idle;
      level   <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      case (state)
        ptw_st_idle: begin
          if (walk_start) begin
            state   <= ptw_st_req;
            level   <= 1'b1;
            fault_q <= 1'b0;
          end
        end
        ptw_st_req: begin
          if (ptw_req_ready) begin
            state <= ptw_st_wait;
          end
        end
        ptw_st_wait: begin
          if (ptw_resp_valid) begin
            if (pte_bad) begin
              fault_q <= 1'b1;
              state   <= ptw_st_done;
            end else if (pte_leaf) begin
              state <= ptw_st_done;
            end else begin
              // Pointer, descend one level
              level <= 1'b0;
              state <= ptw_st_req;
            end
          end
        end
        default: begin
          state <= ptw_st_idle;
        end
      endcase
    end
  end

  // Address and leaf capture
  always_ff @(posedge clk) begin
    if (state == ptw_st_idle && walk_start) begin
      va_q   <= walk_vaddr;
      addr_q <= root_addr[xlen-1:0];
    end
    if (state == ptw_st_wait && ptw_resp_valid) begin
      if (!pte_leaf) begin
        addr_q <= {ptw_resp_data[29:10], va_q.as_page.vpn0, 2'b00};
      end
      leaf_ppn   <= ptw_resp_data[29:10];
      leaf_flags <= ptw_resp_data[7:0];
      leaf_mega  <= level;
    end
  end

  assign ptw_req_valid = (state == ptw_st_req);
  assign ptw_req_addr  = addr_q;

  assign walk_done  = (state == ptw_st_done);
  assign walk_fault = walk_done && fault_q;

  // Fill pulses with walk_done
  assign upd.valid = walk_done && !fault_q;
  assign upd.vpn   = {va_q.as_page.vpn1, va_q.as_page.vpn0};
  assign upd.ppn   = leaf_ppn;
  assign upd.flags = leaf_flags;
  assign upd.mega  = leaf_mega;

  // Router waits for the previous walk to drain
  assert property (@(posedge clk) disable iff (!reset_n) walk_start |-> state == ptw_st_idle);

  // Request held steady under back-pressure
  assert property (@(posedge clk) disable iff (!reset_n)
    ptw_req_valid && !ptw_req_ready |=> ptw_req_valid && $stable(ptw_req_addr));

endmodule

/* hdl/tlb.sv */
/*
 * Fully associative Sv32 TLB
 * Combinational lookup with permission check, round-robin fill
 * from the walker, flush of all entries or of one page
 */

`timescale 1ns/1ps

module tlb import mmu_pkg::*; #(
  parameter int num_entries = 8
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              lookup_valid,
  input  sv32_vaddr_t       lookup_vaddr,
  input  logic              lookup_is_store,
  input  logic              lookup_is_fetch,
  input  logic [1:0]        privilege_mode,
  input  logic              mstatus_sum,
  input  logic              mstatus_mxr,
  input  logic              flush_all,
  input  logic              flush_vaddr,
  input  sv32_vaddr_t       flush_addr,
  output logic              lookup_hit,
  output logic [xlen-1:0]   lookup_paddr,
  output logic              lookup_fault,
  tlb_update_if.tlb         upd
);

  // Entry storage, only the valid bits are control state
  logic [num_entries-1:0]          ent_valid;
  logic [19:0]                     ent_vpn   [num_entries];
  logic [19:0]                     ent_ppn   [num_entries];
  logic [7:0]                      ent_flags [num_entries];
  logic [num_entries-1:0]          ent_mega;
  logic [$clog2(num_entries)-1:0]  fill_ptr;

  logic [num_entries-1:0] match;
  logic [num_entries-1:0] flush_match;
  logic [19:0]            sel_ppn;
  logic [7:0]             sel_flags;
  logic                   sel_mega;
  logic                   priv_ok;
  logic                   access_ok;

  // Megapage entries compare vpn1 only
  function automatic logic vpn_match(logic [19:0] vpn, logic mega, sv32_vaddr_t va);
    return (vpn[19:10] == va.as_page.vpn1) && (mega || vpn[9:0] == va.as_page.vpn0);
  endfunction

  // ==========================================================================
  // Lookup
  // ==========================================================================

  always_comb begin
    sel_ppn   = '0;
    sel_flags = '0;
    sel_mega  = 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      match[i]       = ent_valid[i] && vpn_match(ent_vpn[i], ent_mega[i], lookup_vaddr);
      flush_match[i] = ent_valid[i] && vpn_match(ent_vpn[i], ent_mega[i], flush_addr);
      // One-hot hit, so OR-ing the fields selects the entry
      if (match[i]) begin
        sel_ppn   |= ent_ppn[i];
        sel_flags |= ent_flags[i];
        sel_mega  |= ent_mega[i];
      end
    end
  end

  assign lookup_hit = lookup_valid && (|match);

  // Megapage keeps 22 offset bits
  assign lookup_paddr = sel_mega ? {sel_ppn[19:10], lookup_vaddr.as_mega.offset}
                                 : {sel_ppn, lookup_vaddr.as_page.offset};

  // U pages need U mode, or S mode with SUM
  assign priv_ok = sel_flags[pte_u] ? (privilege_mode == priv_u ||
                                       (privilege_mode == priv_s && mstatus_sum))
                                    : (privilege_mode != priv_u);

  // Fetch needs X, store needs W and D, load needs R or X under MXR
  assign access_ok = lookup_is_fetch ? sel_flags[pte_x] :
                     lookup_is_store ? (sel_flags[pte_w] && sel_flags[pte_d]) :
                     (sel_flags[pte_r] || (sel_flags[pte_x] && mstatus_mxr));

  // No hardware A update, clear A always faults
  assign lookup_fault = lookup_hit && !(priv_ok && access_ok && sel_flags[pte_a]);

  // ==========================================================================
  // Fill and flush
  // ==========================================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ent_valid <= '0;
      fill_ptr  <= '0;
    end else begin
      for (int i = 0; i < num_entries; i++) begin
        if (flush_all || (flush_vaddr && flush_match[i])) begin
          ent_valid[i] <= 1'b0;
        end
      end
      // Install wins over a same-cycle page flush
      if (upd.valid) begin
        ent_valid[fill_ptr] <= 1'b1;
        if (int'(fill_ptr) == num_entries - 1) begin
          fill_ptr <= '0;
        end else begin
          fill_ptr <= fill_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (upd.valid) begin
      ent_vpn[fill_ptr]   <= upd.vpn;
      ent_ppn[fill_ptr]   <= upd.ppn;
      ent_flags[fill_ptr] <= upd.flags;
      ent_mega[fill_ptr]  <= upd.mega;
    end
  end

  // Walker only fills on a miss, so entries never overlap
  assert property (@(posedge clk) disable iff (!reset_n) $onehot0(match));

  // Global flush and install never share a cycle
  assert property (@(posedge clk) disable iff (!reset_n) !(upd.valid && flush_all));

endmodule

/* hdl/tlb_update_if.sv */
/*
 * TLB fill bus
 * One finished walk result, vpn to ppn with leaf flags and page size
 */

`timescale 1ns/1ps

interface tlb_update_if;

  logic        valid;
  // Full 20-bit VPN, low half ignored for megapages
  logic [19:0] vpn;
  logic [19:0] ppn;
  // PTE bits 7:0
  logic [7:0]  flags;
  logic        mega;

  // Source side
  modport walker (output valid, vpn, ppn, flags, mega);

  // Sink side
  modport tlb (input valid, vpn, ppn, flags, mega);

endinterface

/* verification/dual_tlb_mmu_tb.sv */
/*
 * Dual TLB MMU testbench
 * Page table memory model with random back-pressure, a stimulus table
 * of fetch and data accesses, response checks and a cycle limit
 */

`timescale 1ns/1ps

module dual_tlb_mmu_tb import mmu_pkg::*;;

  typedef enum {port_if, port_ex, port_both} port_e;
  typedef enum {no_flush, flush_page, flush_every} flush_e;

  // One table row, vaddr drives the data port or the only active port
  typedef struct {
    port_e       port;
    logic [31:0] vaddr;
    logic [31:0] if_vaddr;
    logic        is_store;
    logic [1:0]  priv;
    logic        sum;
    logic        mxr;
    logic        mode;
    flush_e      flush;
    logic [31:0] exp_paddr;
    logic [31:0] exp_if_paddr;
    logic        exp_fault;
    int          exp_reads;
  } step_t;

  logic clk, reset_n;
  logic if_req_valid, if_req_ready, if_req_page_fault;
  logic [31:0] if_req_vaddr, if_req_paddr, if_req_fault_vaddr;
  logic ex_req_valid, ex_req_is_store, ex_req_ready, ex_req_page_fault;
  logic [31:0] ex_req_vaddr, ex_req_paddr, ex_req_fault_vaddr;
  logic ptw_req_valid, ptw_req_ready, ptw_resp_valid;
  logic [31:0] ptw_req_addr, ptw_resp_data;
  logic [31:0] satp;
  logic [1:0]  privilege_mode;
  logic mstatus_sum, mstatus_mxr;
  logic tlb_flush_all, tlb_flush_vaddr;
  logic [31:0] tlb_flush_addr;

  step_t       steps[$];
  logic [31:0] page_table [logic [31:0]];
  logic [21:0] root_ppn = 22'h00080;
  integer      seed = 50883;
  int          errors, checks, row_idx, cycle_count, cycle_limit;
  int          reads, req_cycles, resp_wait;
  logic [31:0] first_addr, resp_word, rnd;

  mmu_clock_gen clock_gen (.clk, .reset_n);

  dual_tlb_mmu DUT (.*);

  // ==========================================================================
  // Page table memory model
  // ==========================================================================

  // Unmapped words read as zero, an invalid PTE
  function automatic logic [31:0] pte_at(logic [31:0] addr);
    return page_table.exists(addr) ? page_table[addr] : 32'h0;
  endfunction

  task automatic load_page_table();
    // Root pointer to the level-0 table at PPN 0x81
    page_table[32'h0008_0004] = 32'h0002_0401;
    // 4K page VRWXAD, supervisor only
    page_table[32'h0008_1004] = 32'h048D_14CF;
    // Read-only page VRA
    page_table[32'h0008_1008] = 32'h0888_8843;
    // Execute-only page VXA
    page_table[32'h0008_100C] = 32'h0CCC_CC49;
    // User megapage VRXUA
    page_table[32'h0008_0008] = 32'h0A50_005B;
    page_table[32'h0008_000C] = 32'h0000_0000;
    // Megapage with a nonzero low PPN
    page_table[32'h0008_0010] = 32'h0B00_044F;
  endtask

  // Ready is random each cycle, answer 1 to 3 cycles after acceptance
  always @(negedge clk) begin
    ptw_resp_valid = 1'b0;
    if (resp_wait > 0) begin
      resp_wait--;
      if (resp_wait == 0) begin
        ptw_resp_valid = 1'b1;
        ptw_resp_data  = resp_word;
      end
    end
    if (ptw_req_valid) begin
      req_cycles++;
    end
    rnd = $random(seed);
    ptw_req_ready = rnd[0];
    // Accepted on the coming rising edge
    if (ptw_req_valid && ptw_req_ready) begin
      reads++;
      if (reads == 1) begin
        first_addr = ptw_req_addr;
      end
      resp_word = pte_at(ptw_req_addr);
      rnd = $random(seed);
      resp_wait = 1 + int'($unsigned(rnd) % 3);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: run still busy after %0d cycles at row %0d", cycle_count, row_idx);
      $display("Errors found");
      $finish;
    end
  end

  // ==========================================================================
  // Checks and stimulus
  // ==========================================================================

  task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: row %0d %s got %h expected %h",
               $time, row_idx, what, got, exp);
    end
  endtask

  task automatic check_port(string name, logic [31:0] paddr, logic fault,
                            logic [31:0] fault_va, logic [31:0] va,
                            logic [31:0] exp_pa, logic exp_fault);
    check_word({name, " page_fault"}, 32'(fault), 32'(exp_fault));
    if (exp_fault) begin
      check_word({name, " fault_vaddr"}, fault_va, va);
    end else begin
      check_word({name, " paddr"}, paddr, exp_pa);
    end
  endtask

  function automatic void add_step(port_e port, logic [31:0] vaddr, logic [31:0] if_vaddr,
                                   logic is_store, logic [1:0] priv, logic sum, logic mxr,
                                   logic mode, flush_e flush, logic [31:0] exp_paddr,
                                   logic [31:0] exp_if_paddr, logic exp_fault, int exp_reads);
    steps.push_back('{port, vaddr, if_vaddr, is_store, priv, sum, mxr, mode, flush,
                      exp_paddr, exp_if_paddr, exp_fault, exp_reads});
  endfunction

  task automatic build_steps();
    // Bare, satp off or machine mode
    add_step(port_ex, 32'h0040_1abc, 0, 0, priv_s, 0, 0, 0, no_flush, 32'h0040_1abc, 0, 0, 0);
    add_step(port_if, 32'h1234_5678, 0, 0, priv_s, 0, 0, 0, no_flush, 32'h1234_5678, 0, 0, 0);
    add_step(port_ex, 32'h0081_2345, 0, 1, priv_m, 0, 0, 1, no_flush, 32'h0081_2345, 0, 0, 0);
    add_step(port_if, 32'h0040_1000, 0, 0, priv_m, 0, 0, 1, no_flush, 32'h0040_1000, 0, 0, 0);
    // 4K and megapage walks then hits
    add_step(port_ex, 32'h0040_1abc, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h1234_5abc, 0, 0, 2);
    add_step(port_ex, 32'h0040_1ffc, 0, 1, priv_s, 0, 0, 1, no_flush, 32'h1234_5ffc, 0, 0, 0);
    add_step(port_if, 32'h0040_1010, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h1234_5010, 0, 0, 2);
    add_step(port_if, 32'h0040_1020, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h1234_5020, 0, 0, 0);
    add_step(port_ex, 32'h0081_2345, 0, 0, priv_u, 0, 0, 1, no_flush, 32'h2941_2345, 0, 0, 1);
    add_step(port_ex, 32'h00bf_ff00, 0, 0, priv_u, 0, 0, 1, no_flush, 32'h297f_ff00, 0, 0, 0);
    // Permission faults
    add_step(port_ex, 32'h0040_2010, 0, 1, priv_s, 0, 0, 1, no_flush, 32'h2222_2010, 0, 1, 2);
    add_step(port_ex, 32'h0040_2010, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h2222_2010, 0, 0, 0);
    add_step(port_if, 32'h0040_2000, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h2222_2000, 0, 1, 2);
    add_step(port_ex, 32'h0081_2000, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h2941_2000, 0, 1, 0);
    add_step(port_ex, 32'h0081_2000, 0, 0, priv_s, 1, 0, 1, no_flush, 32'h2941_2000, 0, 0, 0);
    add_step(port_ex, 32'h0040_3044, 0, 0, priv_s, 0, 1, 1, no_flush, 32'h3333_3044, 0, 0, 2);
    add_step(port_ex, 32'h0040_3048, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h3333_3048, 0, 1, 0);
    // Walk faults are never cached
    add_step(port_ex, 32'h00c0_0123, 0, 0, priv_s, 0, 0, 1, no_flush, 0, 0, 1, 1);
    add_step(port_ex, 32'h00c0_0123, 0, 0, priv_s, 0, 0, 1, no_flush, 0, 0, 1, 1);
    add_step(port_if, 32'h0100_0456, 0, 0, priv_s, 0, 0, 1, no_flush, 0, 0, 1, 1);
    add_step(port_ex, 32'h0100_0456, 0, 0, priv_s, 0, 0, 1, no_flush, 0, 0, 1, 1);
    // Two misses at once, data walk goes first
    add_step(port_both, 32'h0081_2345, 32'h0040_1abc, 0, priv_s, 1, 0, 1, flush_every,
             32'h2941_2345, 32'h1234_5abc, 0, 3);
    // Page flush hits both TLBs, global flush empties them
    add_step(port_ex, 32'h0040_1abc, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h1234_5abc, 0, 0, 2);
    add_step(port_ex, 32'h0040_2abc, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h2222_2abc, 0, 0, 2);
    add_step(port_ex, 32'h0040_1abc, 0, 0, priv_s, 0, 0, 1, flush_page, 32'h1234_5abc, 0, 0, 2);
    add_step(port_ex, 32'h0040_2abc, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h2222_2abc, 0, 0, 0);
    add_step(port_ex, 32'h0081_2345, 0, 0, priv_s, 1, 0, 1, no_flush, 32'h2941_2345, 0, 0, 0);
    add_step(port_if, 32'h0040_1abc, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h1234_5abc, 0, 0, 2);
    add_step(port_ex, 32'h0040_2abc, 0, 0, priv_s, 0, 0, 1, flush_every, 32'h2222_2abc, 0, 0, 2);
    add_step(port_ex, 32'h0081_2345, 0, 0, priv_s, 1, 0, 1, no_flush, 32'h2941_2345, 0, 0, 1);
    add_step(port_if, 32'h0040_1abc, 0, 0, priv_s, 0, 0, 1, no_flush, 32'h1234_5abc, 0, 0, 2);
  endtask

  task automatic apply_step(step_t s);
    logic        if_wait;
    logic        ex_wait;
    int          waited;
    logic [31:0] if_va;
    logic [31:0] if_pa;
    if_va = (s.port == port_both) ? s.if_vaddr : s.vaddr;
    if_pa = (s.port == port_both) ? s.exp_if_paddr : s.exp_paddr;
    satp           = {s.mode, 9'h000, root_ppn};
    privilege_mode = s.priv;
    mstatus_sum    = s.sum;
    mstatus_mxr    = s.mxr;
    // Flush gets one cycle of its own
    if (s.flush != no_flush) begin
      tlb_flush_addr  = s.vaddr;
      tlb_flush_all   = (s.flush == flush_every);
      tlb_flush_vaddr = (s.flush == flush_page);
      @(negedge clk);
      tlb_flush_all   = 1'b0;
      tlb_flush_vaddr = 1'b0;
    end
    reads      = 0;
    req_cycles = 0;
    waited     = 0;
    if_wait = (s.port != port_ex);
    ex_wait = (s.port != port_if);
    if_req_valid    = if_wait;
    if_req_vaddr    = if_va;
    ex_req_valid    = ex_wait;
    ex_req_vaddr    = s.vaddr;
    ex_req_is_store = s.is_store;
    // Each port holds valid until its own ready
    while (if_wait || ex_wait) begin
      @(negedge clk);
      waited++;
      if (ex_wait && ex_req_ready) begin
        check_port("ex", ex_req_paddr, ex_req_page_fault, ex_req_fault_vaddr,
                   s.vaddr, s.exp_paddr, s.exp_fault);
        ex_req_valid = 1'b0;
        ex_wait      = 1'b0;
      end
      if (if_wait && if_req_ready) begin
        check_port("if", if_req_paddr, if_req_page_fault, if_req_fault_vaddr,
                   if_va, if_pa, s.exp_fault);
        if_req_valid = 1'b0;
        if_wait      = 1'b0;
      end
    end
    // Room for a stray walk to show up
    repeat (2) @(negedge clk);
    check_word("memory reads", reads, s.exp_reads);
    if (s.exp_reads == 0) begin
      check_word("cycles to ready", waited, 1);
      check_word("ptw_req_valid cycles", req_cycles, 0);
    end else begin
      // Root PPN times 4096 plus vpn1 times 4, data port first
      check_word("first PTE address", first_addr,
                 (32'(root_ppn) << page_shift) + 32'(s.vaddr[31:22]) * 4);
    end
  endtask

  initial begin
    errors = 0;
    checks = 0;
    row_idx = 0;
    cycle_count = 0;
    cycle_limit = 0;
    reads = 0;
    req_cycles = 0;
    resp_wait = 0;
    first_addr = '0;
    if_req_valid = 1'b0;
    if_req_vaddr = '0;
    ex_req_valid = 1'b0;
    ex_req_vaddr = '0;
    ex_req_is_store = 1'b0;
    ptw_req_ready = 1'b0;
    ptw_resp_valid = 1'b0;
    ptw_resp_data = '0;
    satp = '0;
    privilege_mode = priv_m;
    mstatus_sum = 1'b0;
    mstatus_mxr = 1'b0;
    tlb_flush_all = 1'b0;
    tlb_flush_vaddr = 1'b0;
    tlb_flush_addr = '0;
    load_page_table();
    build_steps();
    cycle_limit = steps.size() * 40;
    wait (reset_n === 1'b1);
    @(negedge clk);
    check_word("ptw_req_valid after reset", 32'(ptw_req_valid), 0);
    for (int i = 0; i < steps.size(); i++) begin
      row_idx = i;
      apply_step(steps[i]);
    end
    $display("Rows: %0d  checks: %0d  errors: %0d", steps.size(), checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verification/mmu_clock_gen.sv */
/*
 * MMU testbench clock and reset
 * 40 ns clock, active-low reset held for three cycles
 */

`timescale 1ns/1ps

module mmu_clock_gen (
  output logic clk,
  output logic reset_n
);

  // 25 MHz
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Release on a falling edge, away from the flops
  initial begin
    reset_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  end

endmodule
